/* bypass_pkg.sv */
// Bypass and hazard package
// Shared widths, register and CSR index types and the forwarding select encodings

package bypass_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and port counts
  ////////////////////////////////////////////////////////////////////////////

  // Register file index width for the 32 integer registers
  localparam int unsigned RF_ADDR_W = 5;

  // CSR index width as given by the csr field of the instruction
  localparam int unsigned CSR_ADDR_W = 12;

  // ID reads at most two source registers per instruction
  localparam int unsigned NUM_READ_PORTS = 2;

  // Read port numbering, operand A is rs1 and operand B is rs2
  localparam int unsigned RF_PORT_A = 0;
  localparam int unsigned RF_PORT_B = 1;

  ////////////////////////////////////////////////////////////////////////////
  // Index types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [RF_ADDR_W-1:0]  rf_addr_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding mux selects
  ////////////////////////////////////////////////////////////////////////////

  // Operand mux select in ID
  // The value 2'b11 is not produced by this controller
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } op_fw_sel_e;

  // Jump-register target mux select
  // Only WB can feed the jump target since EX results arrive too late
  typedef enum logic {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jalr_fw_sel_e;

endpackage

/* stage_info_if.sv */
// Pipeline stage write-side information
// Carries what one stage (EX or WB) will write back to the RF or the CSRs

`timescale 1ns/10ps

interface stage_info_if import bypass_pkg::*; ();

  // Stage holds a live instruction
  logic     instr_valid;
  // Register file write request and its target register
  logic     rf_we;
  rf_addr_t rf_waddr;
  // Load or store in this stage
  logic     lsu_en;
  // Explicit CSR access, and whether it also writes other CSRs implicitly
  logic     csr_en;
  logic     csr_impl_wr;
  // System instructions that touch machine state
  logic     sys_mret;
  logic     sys_wfi;

  // The top level fills the bundle from its flat ports
  modport producer (
    output instr_valid, rf_we, rf_waddr, lsu_en,
    output csr_en, csr_impl_wr, sys_mret, sys_wfi
  );

  // Hazard logic only ever observes the stage
  modport consumer (
    input instr_valid, rf_we, rf_waddr, lsu_en,
    input csr_en, csr_impl_wr, sys_mret, sys_wfi
  );

endinterface

/* rf_hazard_match.sv */
// Register hazard match
// Compares the ID source registers against the EX and WB destination registers

`timescale 1ns/10ps

module rf_hazard_match import bypass_pkg::*; (
  // Decoded register reads in ID
  input  logic [NUM_READ_PORTS-1:0] rf_re_id_i,
  input  rf_addr_t                  rf_raddr_id_i [NUM_READ_PORTS],

  // Write side of the younger pipeline stages
  stage_info_if.consumer            ex_info_i,
  stage_info_if.consumer            wb_info_i,

  // Qualified hits, one bit per read port
  output logic [NUM_READ_PORTS-1:0] ex_hit_o,
  output logic [NUM_READ_PORTS-1:0] wb_hit_o,

  // Operand A hits for the jump-register target path
  output logic                      ex_jalr_hit_o,
  output logic                      wb_jalr_hit_o
);

  // A stage only produces a register result when it is valid and writes the RF
  logic ex_rf_wr;
  logic wb_rf_wr;

  // Reads of x0 always return zero and never need a bypass
  logic raddr_a_nz;

  assign ex_rf_wr = ex_info_i.instr_valid && ex_info_i.rf_we;
  assign wb_rf_wr = wb_info_i.instr_valid && wb_info_i.rf_we;

  assign raddr_a_nz = |rf_raddr_id_i[RF_PORT_A];

  ////////////////////////////////////////////////////////////////////////////
  // Per-port operand hits
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : gen_port_hit
    logic rd_active;

    // Port is read and is not x0
    assign rd_active = rf_re_id_i[p] && (|rf_raddr_id_i[p]);

    assign ex_hit_o[p] = ex_rf_wr && rd_active && (ex_info_i.rf_waddr == rf_raddr_id_i[p]);
    assign wb_hit_o[p] = wb_rf_wr && rd_active && (wb_info_i.rf_waddr == rf_raddr_id_i[p]);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Jump-register hits
  ////////////////////////////////////////////////////////////////////////////

  // A jump-register instruction always reads rs1, so the read enable is not needed
  // These hits are not qualified with the jump itself, the stall logic does that
  assign ex_jalr_hit_o = ex_rf_wr && raddr_a_nz &&
                         (ex_info_i.rf_waddr == rf_raddr_id_i[RF_PORT_A]);
  assign wb_jalr_hit_o = wb_rf_wr && raddr_a_nz &&
                         (wb_info_i.rf_waddr == rf_raddr_id_i[RF_PORT_A]);

endmodule

/* operand_forward_sel.sv */
// Operand forwarding select
// Turns the register hits into mux selects for operands A and B and the jump target

`timescale 1ns/10ps

module operand_forward_sel import bypass_pkg::*; (
  // Qualified hits from the register match
  input  logic [NUM_READ_PORTS-1:0] ex_hit_i,
  input  logic [NUM_READ_PORTS-1:0] wb_hit_i,
  input  logic                      wb_jalr_hit_i,

  // Mux selects towards the ID operand muxes
  output op_fw_sel_e                operand_a_fw_sel_o,
  output op_fw_sel_e                operand_b_fw_sel_o,
  output jalr_fw_sel_e              jalr_fw_sel_o
);

  // EX holds the newer value of a register, so it wins over WB
  function automatic op_fw_sel_e pick_sel(input logic ex_hit, input logic wb_hit);
    op_fw_sel_e sel;
    if (ex_hit) begin
      sel = SEL_FW_EX;
    end else if (wb_hit) begin
      sel = SEL_FW_WB;
    end else begin
      sel = SEL_REGFILE;
    end
    return sel;
  endfunction

  assign operand_a_fw_sel_o = pick_sel(ex_hit_i[RF_PORT_A], wb_hit_i[RF_PORT_A]);
  assign operand_b_fw_sel_o = pick_sel(ex_hit_i[RF_PORT_B], wb_hit_i[RF_PORT_B]);

  // Jump target only takes ALU results from WB
  // A load in WB or a writer in EX is handled by the jump-register stall instead
  assign jalr_fw_sel_o = wb_jalr_hit_i ? SELJ_FW_WB : SELJ_REGFILE;

endmodule

/* csr_hazard_detect.sv */
// CSR hazard detection
// Finds CSR read-after-write hazards between ID, EX and WB and raises the CSR stalls

`timescale 1ns/10ps

module csr_hazard_detect import bypass_pkg::*; (
  // ID instructions with implicit CSR reads
  input  logic           instr_valid_id_i,
  input  logic           mret_id_i,
  input  logic           wfi_id_i,

  // Stage write information
  stage_info_if.consumer ex_info_i,
  stage_info_if.consumer wb_info_i,

  // CSR reads in EX and the explicit CSR write in WB
  input  logic           csr_impl_re_ex_i,
  input  logic           csr_re_ex_i,
  input  csr_addr_t      csr_raddr_ex_i,
  input  logic           csr_we_wb_i,
  input  csr_addr_t      csr_waddr_wb_i,

  output logic           csr_stall_id_o,
  output logic           csr_stall_ex_o
);

  // mret restores mstatus, and some CSR instructions update other CSRs as a side effect
  function automatic logic impl_write(input logic valid, input logic mret,
                                      input logic csr_en, input logic impl_wr);
    return valid && (mret || (csr_en && impl_wr));
  endfunction

  logic csr_impl_wr_ex;
  logic csr_impl_wr_wb;
  logic csr_wr_ex;
  logic csr_wr_wb;
  logic csr_impl_rd_id;
  logic csr_expl_hz_ex;

  assign csr_impl_wr_ex = impl_write(ex_info_i.instr_valid, ex_info_i.sys_mret,
                                     ex_info_i.csr_en, ex_info_i.csr_impl_wr);
  assign csr_impl_wr_wb = impl_write(wb_info_i.instr_valid, wb_info_i.sys_mret,
                                     wb_info_i.csr_en, wb_info_i.csr_impl_wr);

  // Any CSR write per stage, explicit or implicit
  assign csr_wr_ex = ex_info_i.instr_valid && (ex_info_i.csr_en || csr_impl_wr_ex);
  assign csr_wr_wb = wb_info_i.instr_valid && (wb_info_i.csr_en || csr_impl_wr_wb);

  ////////////////////////////////////////////////////////////////////////////
  // ID stall
  ////////////////////////////////////////////////////////////////////////////

  // mret reads mepc and mcause in ID and WFI reads mstatus
  assign csr_impl_rd_id = instr_valid_id_i && (mret_id_i || wfi_id_i);

  // Conservative, any CSR write still in flight holds the reader back
  assign csr_stall_id_o = csr_impl_rd_id && (csr_wr_ex || csr_wr_wb);

  ////////////////////////////////////////////////////////////////////////////
  // EX stall
  ////////////////////////////////////////////////////////////////////////////

  // Explicit read against explicit write is exact on the CSR address
  assign csr_expl_hz_ex = csr_re_ex_i && csr_we_wb_i && (csr_raddr_ex_i == csr_waddr_wb_i);

  // Implicit reads in EX wait for any write in WB
  // An explicit CSR in EX waits for any implicit write in WB
  assign csr_stall_ex_o = (csr_impl_re_ex_i && csr_wr_wb) ||
                          (ex_info_i.instr_valid && ex_info_i.csr_en && csr_impl_wr_wb) ||
                          csr_expl_hz_ex;

endmodule

/* pipeline_stall_ctrl.sv */
// Pipeline stall control
// Produces the load-use, jump-register and sleep stalls for the ID stage

`timescale 1ns/10ps

module pipeline_stall_ctrl import bypass_pkg::*; (
  // Jump-register instruction in ID
  input  logic                      instr_valid_id_i,
  input  logic                      jalr_id_i,

  // Stage write information
  stage_info_if.consumer            ex_info_i,
  stage_info_if.consumer            wb_info_i,

  // WB can retire this cycle and drops low while it waits on load data
  input  logic                      wb_ready_i,

  // Qualified register hits
  input  logic [NUM_READ_PORTS-1:0] ex_hit_i,
  input  logic [NUM_READ_PORTS-1:0] wb_hit_i,
  input  logic                      ex_jalr_hit_i,
  input  logic                      wb_jalr_hit_i,

  output logic                      load_stall_o,
  output logic                      jalr_stall_o,
  output logic                      sleep_stall_o
);

  logic jalr_id;

  // Load data in EX does not exist yet, and WB has no data while it waits
  // The hits already include valid and rf_we
  assign load_stall_o = (ex_info_i.lsu_en && (|ex_hit_i)) ||
                        (!wb_ready_i && (|wb_hit_i));

  ////////////////////////////////////////////////////////////////////////////
  // Jump register
  ////////////////////////////////////////////////////////////////////////////

  assign jalr_id = instr_valid_id_i && jalr_id_i;

  // The jump target mux only forwards ALU results from WB
  // Any writer in EX or a load in WB must complete first
  assign jalr_stall_o = jalr_id && (ex_jalr_hit_i || (wb_jalr_hit_i && wb_info_i.lsu_en));

  ////////////////////////////////////////////////////////////////////////////
  // Sleep
  ////////////////////////////////////////////////////////////////////////////

  // Hold ID while a WFI in EX decides whether the core goes to sleep
  assign sleep_stall_o = ex_info_i.instr_valid && ex_info_i.sys_wfi;

endmodule

/* hazard_bypass_top.sv */
// Operand bypass and hazard stall controller
// Forwarding selects and ID/EX stalls for a three-stage in-order pipeline

`timescale 1ns/10ps

module hazard_bypass_top import bypass_pkg::*; (
  // ID stage
  input  logic [NUM_READ_PORTS-1:0] rf_re_id_i,
  input  rf_addr_t                  rf_raddr_a_id_i,
  input  rf_addr_t                  rf_raddr_b_id_i,
  input  logic                      instr_valid_id_i,
  input  logic                      jalr_id_i,
  input  logic                      mret_id_i,
  input  logic                      wfi_id_i,

  // EX stage
  input  logic                      ex_valid_i,
  input  logic                      ex_rf_we_i,
  input  rf_addr_t                  ex_rf_waddr_i,
  input  logic                      ex_lsu_en_i,
  input  logic                      ex_csr_en_i,
  input  logic                      ex_csr_impl_wr_i,
  input  logic                      ex_mret_i,
  input  logic                      ex_wfi_i,

  // WB stage
  input  logic                      wb_valid_i,
  input  logic                      wb_rf_we_i,
  input  rf_addr_t                  wb_rf_waddr_i,
  input  logic                      wb_lsu_en_i,
  input  logic                      wb_csr_en_i,
  input  logic                      wb_csr_impl_wr_i,
  input  logic                      wb_mret_i,
  input  logic                      wb_wfi_i,
  input  logic                      wb_ready_i,

  // CSR accesses seen by the CSR file
  input  logic                      csr_impl_re_ex_i,
  input  logic                      csr_re_ex_i,
  input  csr_addr_t                 csr_raddr_ex_i,
  input  logic                      csr_we_wb_i,
  input  csr_addr_t                 csr_waddr_wb_i,

  // Forwarding selects
  output op_fw_sel_e                operand_a_fw_sel_o,
  output op_fw_sel_e                operand_b_fw_sel_o,
  output jalr_fw_sel_e              jalr_fw_sel_o,

  // Stalls
  output logic                      load_stall_o,
  output logic                      jalr_stall_o,
  output logic                      sleep_stall_o,
  output logic                      csr_stall_id_o,
  output logic                      csr_stall_ex_o
);

  stage_info_if ex_info ();
  stage_info_if wb_info ();

  rf_addr_t                  rf_raddr_id [NUM_READ_PORTS];
  logic [NUM_READ_PORTS-1:0] ex_hit;
  logic [NUM_READ_PORTS-1:0] wb_hit;
  logic                      ex_jalr_hit;
  logic                      wb_jalr_hit;

  // Read addresses as an array indexed by port
  assign rf_raddr_id[RF_PORT_A] = rf_raddr_a_id_i;
  assign rf_raddr_id[RF_PORT_B] = rf_raddr_b_id_i;

  ////////////////////////////////////////////////////////////////////////////
  // Stage bundles
  ////////////////////////////////////////////////////////////////////////////

  assign ex_info.instr_valid = ex_valid_i;
  assign ex_info.rf_we       = ex_rf_we_i;
  assign ex_info.rf_waddr    = ex_rf_waddr_i;
  assign ex_info.lsu_en      = ex_lsu_en_i;
  assign ex_info.csr_en      = ex_csr_en_i;
  assign ex_info.csr_impl_wr = ex_csr_impl_wr_i;
  assign ex_info.sys_mret    = ex_mret_i;
  assign ex_info.sys_wfi     = ex_wfi_i;

  assign wb_info.instr_valid = wb_valid_i;
  assign wb_info.rf_we       = wb_rf_we_i;
  assign wb_info.rf_waddr    = wb_rf_waddr_i;
  assign wb_info.lsu_en      = wb_lsu_en_i;
  assign wb_info.csr_en      = wb_csr_en_i;
  assign wb_info.csr_impl_wr = wb_csr_impl_wr_i;
  assign wb_info.sys_mret    = wb_mret_i;
  assign wb_info.sys_wfi     = wb_wfi_i;

  ////////////////////////////////////////////////////////////////////////////
  // Submodules
  ////////////////////////////////////////////////////////////////////////////

  rf_hazard_match u_rf_hazard_match (
    .rf_re_id_i    (rf_re_id_i),
    .rf_raddr_id_i (rf_raddr_id),
    .ex_info_i     (ex_info),
    .wb_info_i     (wb_info),
    .ex_hit_o      (ex_hit),
    .wb_hit_o      (wb_hit),
    .ex_jalr_hit_o (ex_jalr_hit),
    .wb_jalr_hit_o (wb_jalr_hit)
  );

  operand_forward_sel u_operand_forward_sel (
    .ex_hit_i           (ex_hit),
    .wb_hit_i           (wb_hit),
    .wb_jalr_hit_i      (wb_jalr_hit),
    .operand_a_fw_sel_o (operand_a_fw_sel_o),
    .operand_b_fw_sel_o (operand_b_fw_sel_o),
    .jalr_fw_sel_o      (jalr_fw_sel_o)
  );

  csr_hazard_detect u_csr_hazard_detect (
    .instr_valid_id_i (instr_valid_id_i),
    .mret_id_i        (mret_id_i),
    .wfi_id_i         (wfi_id_i),
    .ex_info_i        (ex_info),
    .wb_info_i        (wb_info),
    .csr_impl_re_ex_i (csr_impl_re_ex_i),
    .csr_re_ex_i      (csr_re_ex_i),
    .csr_raddr_ex_i   (csr_raddr_ex_i),
    .csr_we_wb_i      (csr_we_wb_i),
    .csr_waddr_wb_i   (csr_waddr_wb_i),
    .csr_stall_id_o   (csr_stall_id_o),
    .csr_stall_ex_o   (csr_stall_ex_o)
  );

  pipeline_stall_ctrl u_pipeline_stall_ctrl (
    .instr_valid_id_i (instr_valid_id_i),
    .jalr_id_i        (jalr_id_i),
    .ex_info_i        (ex_info),
    .wb_info_i        (wb_info),
    .wb_ready_i       (wb_ready_i),
    .ex_hit_i         (ex_hit),
    .wb_hit_i         (wb_hit),
    .ex_jalr_hit_i    (ex_jalr_hit),
    .wb_jalr_hit_i    (wb_jalr_hit),
    .load_stall_o     (load_stall_o),
    .jalr_stall_o     (jalr_stall_o),
    .sleep_stall_o    (sleep_stall_o)
  );

endmodule

/* tb_checks.svh */
// Typed compare tasks for the bypass controller testbench
// Any wrong value ends the run at once

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  // Prints the cause, then the verdict, and ends the simulation
  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Operand mux selects
  task automatic check_fw_sel(input string name, input op_fw_sel_e exp_sel,
                              input op_fw_sel_e act_sel);
    if (act_sel !== exp_sel) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %s (%0d) got %s (%0d), case %0d",
                              $time, name, exp_sel.name(), exp_sel, act_sel.name(), act_sel,
                              cur_case));
    end
  endtask

  // Jump target mux select
  task automatic check_jalr_sel(input string name, input jalr_fw_sel_e exp_sel,
                                input jalr_fw_sel_e act_sel);
    if (act_sel !== exp_sel) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %s (%0d) got %s (%0d), case %0d",
                              $time, name, exp_sel.name(), exp_sel, act_sel.name(), act_sel,
                              cur_case));
    end
  endtask

  // Single stall flags
  task automatic check_stall(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %b got %b, case %0d",
                              $time, name, exp_val, act_val, cur_case));
    end
  endtask

`endif

/* tb_hazard_bypass.sv */
// Testbench for the operand bypass and hazard stall controller
// Replays the vectors of bypass_cases.txt and checks every output at the falling edge

`timescale 1ns/10ps

module tb_hazard_bypass import bypass_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  // Inputs in port order followed by the eight expected outputs
  localparam int FIELD_COUNT  = 37;
  // Extra cycles the watchdog allows on top of reset and the cases
  localparam int SLACK_CYCLES = 10;

  // One line of the case file
  typedef struct packed {
    logic [NUM_READ_PORTS-1:0] rf_re;
    rf_addr_t     raddr_a;
    rf_addr_t     raddr_b;
    logic         id_valid;
    logic         id_jalr;
    logic         id_mret;
    logic         id_wfi;
    logic         ex_valid;
    logic         ex_rf_we;
    rf_addr_t     ex_waddr;
    logic         ex_lsu;
    logic         ex_csr_en;
    logic         ex_impl_wr;
    logic         ex_mret;
    logic         ex_wfi;
    logic         wb_valid;
    logic         wb_rf_we;
    rf_addr_t     wb_waddr;
    logic         wb_lsu;
    logic         wb_csr_en;
    logic         wb_impl_wr;
    logic         wb_mret;
    logic         wb_wfi;
    logic         wb_ready;
    logic         csr_impl_re;
    logic         csr_re;
    csr_addr_t    csr_raddr;
    logic         csr_we;
    csr_addr_t    csr_waddr;
    op_fw_sel_e   exp_a_sel;
    op_fw_sel_e   exp_b_sel;
    jalr_fw_sel_e exp_jalr_sel;
    logic         exp_load;
    logic         exp_jalr_stall;
    logic         exp_sleep;
    logic         exp_csr_id;
    logic         exp_csr_ex;
  } case_t;

  logic clk;
  logic reset_i;

  // DUT inputs
  logic [NUM_READ_PORTS-1:0] rf_re_id_i;
  rf_addr_t     rf_raddr_a_id_i;
  rf_addr_t     rf_raddr_b_id_i;
  logic         instr_valid_id_i;
  logic         jalr_id_i;
  logic         mret_id_i;
  logic         wfi_id_i;
  logic         ex_valid_i;
  logic         ex_rf_we_i;
  rf_addr_t     ex_rf_waddr_i;
  logic         ex_lsu_en_i;
  logic         ex_csr_en_i;
  logic         ex_csr_impl_wr_i;
  logic         ex_mret_i;
  logic         ex_wfi_i;
  logic         wb_valid_i;
  logic         wb_rf_we_i;
  rf_addr_t     wb_rf_waddr_i;
  logic         wb_lsu_en_i;
  logic         wb_csr_en_i;
  logic         wb_csr_impl_wr_i;
  logic         wb_mret_i;
  logic         wb_wfi_i;
  logic         wb_ready_i;
  logic         csr_impl_re_ex_i;
  logic         csr_re_ex_i;
  csr_addr_t    csr_raddr_ex_i;
  logic         csr_we_wb_i;
  csr_addr_t    csr_waddr_wb_i;

  // DUT outputs
  op_fw_sel_e   operand_a_fw_sel_o;
  op_fw_sel_e   operand_b_fw_sel_o;
  jalr_fw_sel_e jalr_fw_sel_o;
  logic         load_stall_o;
  logic         jalr_stall_o;
  logic         sleep_stall_o;
  logic         csr_stall_id_o;
  logic         csr_stall_ex_o;

  case_t       cases [$];
  int unsigned line_vals [$];
  int          cur_case;
  bit          cases_loaded;

  `include "tb_checks.svh"

  hazard_bypass_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Case file reader
  ////////////////////////////////////////////////////////////////////////////

  // Splits a line into hex fields and skips whatever follows a hash
  function automatic void split_hex_fields(input string line);
    int unsigned value;
    bit          in_field;
    byte         ch;
    int          digit;
    int          i;
    line_vals.delete();
    value    = 0;
    in_field = 1'b0;
    for (i = 0; i < line.len(); i++) begin
      ch = line.getc(i);
      if (ch == "#") begin
        break;
      end
      digit = -1;
      if (ch >= "0" && ch <= "9") begin
        digit = int'(ch - "0");
      end else if (ch >= "a" && ch <= "f") begin
        digit = int'(ch - "a") + 10;
      end else if (ch >= "A" && ch <= "F") begin
        digit = int'(ch - "A") + 10;
      end
      if (digit >= 0) begin
        value    = value * 16 + digit;
        in_field = 1'b1;
      end else if (in_field) begin
        line_vals.push_back(value);
        value    = 0;
        in_field = 1'b0;
      end
    end
    if (in_field) begin
      line_vals.push_back(value);
    end
  endfunction

  // Columns follow the DUT port list, then the expected outputs
  function automatic case_t fields_to_case();
    case_t c;
    c.rf_re          = 2'(line_vals[0]);
    c.raddr_a        = rf_addr_t'(line_vals[1]);
    c.raddr_b        = rf_addr_t'(line_vals[2]);
    c.id_valid       = 1'(line_vals[3]);
    c.id_jalr        = 1'(line_vals[4]);
    c.id_mret        = 1'(line_vals[5]);
    c.id_wfi         = 1'(line_vals[6]);
    c.ex_valid       = 1'(line_vals[7]);
    c.ex_rf_we       = 1'(line_vals[8]);
    c.ex_waddr       = rf_addr_t'(line_vals[9]);
    c.ex_lsu         = 1'(line_vals[10]);
    c.ex_csr_en      = 1'(line_vals[11]);
    c.ex_impl_wr     = 1'(line_vals[12]);
    c.ex_mret        = 1'(line_vals[13]);
    c.ex_wfi         = 1'(line_vals[14]);
    c.wb_valid       = 1'(line_vals[15]);
    c.wb_rf_we       = 1'(line_vals[16]);
    c.wb_waddr       = rf_addr_t'(line_vals[17]);
    c.wb_lsu         = 1'(line_vals[18]);
    c.wb_csr_en      = 1'(line_vals[19]);
    c.wb_impl_wr     = 1'(line_vals[20]);
    c.wb_mret        = 1'(line_vals[21]);
    c.wb_wfi         = 1'(line_vals[22]);
    c.wb_ready       = 1'(line_vals[23]);
    c.csr_impl_re    = 1'(line_vals[24]);
    c.csr_re         = 1'(line_vals[25]);
    c.csr_raddr      = csr_addr_t'(line_vals[26]);
    c.csr_we         = 1'(line_vals[27]);
    c.csr_waddr      = csr_addr_t'(line_vals[28]);
    c.exp_a_sel      = op_fw_sel_e'(line_vals[29]);
    c.exp_b_sel      = op_fw_sel_e'(line_vals[30]);
    c.exp_jalr_sel   = jalr_fw_sel_e'(line_vals[31]);
    c.exp_load       = 1'(line_vals[32]);
    c.exp_jalr_stall = 1'(line_vals[33]);
    c.exp_sleep      = 1'(line_vals[34]);
    c.exp_csr_id     = 1'(line_vals[35]);
    c.exp_csr_ex     = 1'(line_vals[36]);
    return c;
  endfunction

  task automatic load_cases();
    int    fd;
    string line;
    fd = $fopen("bypass_cases.txt", "r");
    if (fd == 0) begin
      stop_on_error("Could not open bypass_cases.txt for reading");
    end
    while ($fgets(line, fd) != 0) begin
      split_hex_fields(line);
      // Blank and comment lines leave no fields
      if (line_vals.size() == 0) begin
        continue;
      end
      if (line_vals.size() != FIELD_COUNT) begin
        stop_on_error($sformatf("Case line has %0d fields instead of %0d: %s",
                                line_vals.size(), FIELD_COUNT, line));
      end
      cases.push_back(fields_to_case());
    end
    $fclose(fd);
    if (cases.size() == 0) begin
      stop_on_error("The case file holds no cases");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driver and checker
  ////////////////////////////////////////////////////////////////////////////

  // Nothing valid anywhere and WB ready, so every output is inactive
  function automatic case_t idle_case();
    case_t c;
    c              = '0;
    c.wb_ready     = 1'b1;
    c.exp_a_sel    = SEL_REGFILE;
    c.exp_b_sel    = SEL_REGFILE;
    c.exp_jalr_sel = SELJ_REGFILE;
    return c;
  endfunction

  task automatic apply_case(input case_t c);
    rf_re_id_i       <= c.rf_re;
    rf_raddr_a_id_i  <= c.raddr_a;
    rf_raddr_b_id_i  <= c.raddr_b;
    instr_valid_id_i <= c.id_valid;
    jalr_id_i        <= c.id_jalr;
    mret_id_i        <= c.id_mret;
    wfi_id_i         <= c.id_wfi;
    ex_valid_i       <= c.ex_valid;
    ex_rf_we_i       <= c.ex_rf_we;
    ex_rf_waddr_i    <= c.ex_waddr;
    ex_lsu_en_i      <= c.ex_lsu;
    ex_csr_en_i      <= c.ex_csr_en;
    ex_csr_impl_wr_i <= c.ex_impl_wr;
    ex_mret_i        <= c.ex_mret;
    ex_wfi_i         <= c.ex_wfi;
    wb_valid_i       <= c.wb_valid;
    wb_rf_we_i       <= c.wb_rf_we;
    wb_rf_waddr_i    <= c.wb_waddr;
    wb_lsu_en_i      <= c.wb_lsu;
    wb_csr_en_i      <= c.wb_csr_en;
    wb_csr_impl_wr_i <= c.wb_impl_wr;
    wb_mret_i        <= c.wb_mret;
    wb_wfi_i         <= c.wb_wfi;
    wb_ready_i       <= c.wb_ready;
    csr_impl_re_ex_i <= c.csr_impl_re;
    csr_re_ex_i      <= c.csr_re;
    csr_raddr_ex_i   <= c.csr_raddr;
    csr_we_wb_i      <= c.csr_we;
    csr_waddr_wb_i   <= c.csr_waddr;
  endtask

  task automatic check_outputs(input case_t c);
    check_fw_sel("operand_a_fw_sel_o", c.exp_a_sel, operand_a_fw_sel_o);
    check_fw_sel("operand_b_fw_sel_o", c.exp_b_sel, operand_b_fw_sel_o);
    check_jalr_sel("jalr_fw_sel_o", c.exp_jalr_sel, jalr_fw_sel_o);
    check_stall("load_stall_o", c.exp_load, load_stall_o);
    check_stall("jalr_stall_o", c.exp_jalr_stall, jalr_stall_o);
    check_stall("sleep_stall_o", c.exp_sleep, sleep_stall_o);
    check_stall("csr_stall_id_o", c.exp_csr_id, csr_stall_id_o);
    check_stall("csr_stall_ex_o", c.exp_csr_ex, csr_stall_ex_o);
  endtask

  initial begin
    cases_loaded = 1'b0;
    cur_case     = -1;
    reset_i      <= 1'b1;
    apply_case(idle_case());
    load_cases();
    cases_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
    // Inputs stayed idle through reset, so the first sample must be inactive
    @(negedge clk);
    check_outputs(idle_case());
    for (int i = 0; i < cases.size(); i++) begin
      @(posedge clk);
      apply_case(cases[i]);
      @(negedge clk);
      cur_case = i;
      check_outputs(cases[i]);
    end
    $display("All tests passed!");
    $finish;
  end

  // Watchdog sized from the number of cases once the file is read
  initial begin : watchdog
    int limit_cycles;
    wait (cases_loaded);
    limit_cycles = cases.size() + RESET_CYCLES + SLACK_CYCLES;
    #(limit_cycles * CLK_PERIOD);
    stop_on_error($sformatf("Watchdog expired after %0d cycles, %0d of %0d cases checked",
                            limit_cycles, cur_case + 1, cases.size()));
  end

endmodule

/* bypass_cases.txt */
# ID: re ra rb v jalr mret wfi | EX: v we waddr lsu csr impl mret wfi | WB: same eight, ready
# CSR: impl_re re raddr we waddr | expected: a_sel b_sel jalr_sel load jalr sleep csr_id csr_ex
3 00 00 0 0 0 0  0 0 00 0 0 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
# Forwarding priority, x0 and read enables
3 05 06 1 0 0 0  1 1 05 0 0 0 0 0  1 1 05 0 0 0 0 0 1  0 0 000 0 000  1 0 1 0 0 0 0 0
3 05 06 1 0 0 0  0 0 00 0 0 0 0 0  1 1 06 0 0 0 0 0 1  0 0 000 0 000  0 2 0 0 0 0 0 0
3 00 00 1 0 0 0  1 1 00 0 0 0 0 0  1 1 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
2 05 07 1 0 0 0  1 1 05 0 0 0 0 0  1 1 07 0 0 0 0 0 1  0 0 000 0 000  0 2 0 0 0 0 0 0
3 08 09 1 0 0 0  1 1 09 0 0 0 0 0  1 1 08 0 0 0 0 0 1  0 0 000 0 000  2 1 1 0 0 0 0 0
3 05 05 1 0 0 0  1 0 05 0 0 0 0 0  0 1 05 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
# Load-use
3 01 0a 1 0 0 0  1 1 0a 1 0 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 1 0 1 0 0 0 0
3 01 0a 1 0 0 0  1 1 0b 1 0 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
3 01 0a 1 0 0 0  0 0 00 0 0 0 0 0  1 1 0a 1 0 0 0 0 0  0 0 000 0 000  0 2 0 1 0 0 0 0
3 01 0a 1 0 0 0  0 0 00 0 0 0 0 0  1 1 0a 1 0 0 0 0 1  0 0 000 0 000  0 2 0 0 0 0 0 0
3 01 0a 1 0 0 0  0 0 00 0 0 0 0 0  1 1 0c 1 0 0 0 0 0  0 0 000 0 000  0 0 0 0 0 0 0 0
1 01 0a 1 0 0 0  1 1 0a 1 0 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
# Jump register
1 0d 00 1 1 0 0  0 0 00 0 0 0 0 0  1 1 0d 0 0 0 0 0 1  0 0 000 0 000  2 0 1 0 0 0 0 0
1 0d 00 1 1 0 0  0 0 00 0 0 0 0 0  1 1 0d 1 0 0 0 0 1  0 0 000 0 000  2 0 1 0 1 0 0 0
1 0d 00 1 1 0 0  1 1 0d 0 0 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  1 0 0 0 1 0 0 0
0 0d 00 1 1 0 0  0 0 00 0 0 0 0 0  1 1 0d 1 0 0 0 0 1  0 0 000 0 000  0 0 1 0 1 0 0 0
1 0d 00 0 1 0 0  1 1 0d 0 0 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  1 0 0 0 0 0 0 0
1 00 00 1 1 0 0  1 1 00 0 0 0 0 0  1 1 00 1 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
# CSR stall in ID
0 00 00 1 0 1 0  1 0 00 0 1 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 1 0
0 00 00 1 0 0 1  1 0 00 0 1 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 1 0
0 00 00 1 0 1 0  0 0 00 0 0 0 0 0  1 0 00 0 0 0 1 0 1  0 0 000 0 000  0 0 0 0 0 0 1 0
0 00 00 1 0 1 0  0 0 00 0 0 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
0 00 00 1 0 1 0  0 0 00 0 1 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
0 00 00 0 0 1 0  1 0 00 0 1 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
# CSR stall in EX
0 00 00 0 0 0 0  0 0 00 0 0 0 0 0  0 0 00 0 0 0 0 0 1  0 1 300 1 300  0 0 0 0 0 0 0 1
0 00 00 0 0 0 0  0 0 00 0 0 0 0 0  0 0 00 0 0 0 0 0 1  0 1 300 1 305  0 0 0 0 0 0 0 0
0 00 00 0 0 0 0  1 0 00 0 1 0 0 0  1 0 00 0 1 1 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 1
0 00 00 0 0 0 0  1 0 00 0 1 0 0 0  1 0 00 0 1 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
0 00 00 0 0 0 0  0 0 00 0 0 0 0 0  1 0 00 0 1 0 0 0 1  1 0 000 0 000  0 0 0 0 0 0 0 1
0 00 00 0 0 0 0  0 0 00 0 0 0 0 0  0 0 00 0 1 0 0 0 1  1 0 000 0 000  0 0 0 0 0 0 0 0
0 00 00 0 0 0 0  1 0 00 0 1 0 0 0  1 0 00 0 0 0 1 0 1  0 0 000 0 000  0 0 0 0 0 0 0 1
# Sleep
0 00 00 0 0 0 0  1 0 00 0 0 0 0 1  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 1 0 0
0 00 00 0 0 0 0  0 0 00 0 0 0 0 1  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0
0 00 00 1 0 1 0  1 0 00 0 0 0 0 1  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 1 0 0
3 00 00 0 0 0 0  0 0 00 0 0 0 0 0  0 0 00 0 0 0 0 0 1  0 0 000 0 000  0 0 0 0 0 0 0 0

/* src.f */
+incdir+.
bypass_pkg.sv
stage_info_if.sv
rf_hazard_match.sv
operand_forward_sel.sv
csr_hazard_detect.sv
pipeline_stall_ctrl.sv
hazard_bypass_top.sv
tb_hazard_bypass.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the bypass controller testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

TOP=tb_hazard_bypass
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -j 0 \
  --top-module "$TOP" \
  -f src.f \
  -o "$TOP"

# The status is kept so that the log is searched even after a fatal stop
sim_status=0
./obj_dir/"$TOP" > "$LOG" 2>&1 || sim_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit "$sim_status"
fi
echo "Simulation PASSED"
